// ==== verilog/trs_io_pkg.sv ====
`default_nettype none

package trs_io_pkg;

  // opcodes sent by the microcontroller
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    dbus_read        = 8'd3,
    dbus_write       = 8'd4,   // followed by one param byte
    data_ready       = 8'd5,
    get_version      = 8'd15,
    get_printer_byte = 8'd16,
    abus_read        = 8'd18
  } cmd_op_t;

  // service code shown to the microcontroller on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    printer_wr = 4'd4,
    svc_idle   = 4'hf          // nothing pending
  } esp_svc_t;

  localparam logic [7:0]  COOKIE          = 8'haf;
  localparam logic [2:0]  VERSION_MAJOR   = 3'd0;
  localparam logic [4:0]  VERSION_MINOR   = 5'd3;
  localparam logic [7:0]  PRINTER_READY   = 8'h30;
  localparam logic [7:0]  PRINTER_BUSY    = 8'hf0;
  localparam logic [7:0]  TRS_IO_PORT     = 8'd31;
  localparam logic [3:0]  FREHD_PORT_HI   = 4'hc;     // ports c0h..cfh
  localparam logic [15:0] PRINTER_ADDR    = 16'h37e8;
  localparam logic [15:0] FDC_STATUS_ADDR = 16'h37e0;

  // z80 strobes, active high here
  typedef struct packed {
    logic rd;
    logic wr;
    logic in;
    logic out;
  } bus_strobe_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
    bus_strobe_t strb;
  } trs_bus_t;

  typedef struct packed {
    logic        valid;  // one cycle strobe
    cmd_op_t     op;
    logic [7:0]  param;
  } cmd_exec_t;

  // device selects, all levels except access
  typedef struct packed {
    logic trs_io_in;
    logic trs_io_out;
    logic frehd_in;
    logic frehd_out;
    logic printer_wr;
    logic printer_rd;
    logic fdc_status_rd;
    logic access;        // pulse on filtered strobe edge
  } dev_sel_t;

endpackage

`default_nettype wire

// ==== verilog/spi_byte_link.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_byte_link #(
  parameter int SYNC_STAGES = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       rx_valid,
  output logic [7:0] rx_byte,
  input  logic       tx_load,
  input  logic [7:0] tx_byte,
  output logic       miso
);

  logic [SYNC_STAGES-1:0] sck_sync, cs_n_sync, mosi_sync;
  logic       sck_prev;
  logic       sck_rise, sck_fall;
  logic       cs_active, mosi_s;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  // pin synchronizers, msb is the settled value
  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync  <= '0;
      cs_n_sync <= '1;  // start deselected
      mosi_sync <= '0;
      sck_prev  <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[SYNC_STAGES-2:0], sck};
      cs_n_sync <= {cs_n_sync[SYNC_STAGES-2:0], cs_n};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
      sck_prev  <= sck_sync[SYNC_STAGES-1];
    end
  end

  assign sck_rise  = sck_sync[SYNC_STAGES-1] & ~sck_prev;
  assign sck_fall  = ~sck_sync[SYNC_STAGES-1] & sck_prev;
  assign cs_active = ~cs_n_sync[SYNC_STAGES-1];
  assign mosi_s    = mosi_sync[SYNC_STAGES-1];  // same depth as sck

  // bit counter and byte strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active & sck_rise & (bit_cnt == 3'd7);
      if (!cs_active)
        bit_cnt <= 3'd0;              // resync on deselect
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_s};  // msb first
  end

  assign rx_byte = rx_shift;

  // tx shifter, the falling edge after bit 8 is skipped so a fresh load survives
  always_ff @(posedge clk) begin
    if (rst)
      tx_shift <= 8'hff;
    else if (tx_load)
      tx_shift <= tx_byte;
    else if (cs_active && sck_fall && bit_cnt != 3'd0)
      tx_shift <= {tx_shift[6:0], 1'b1};
  end

  assign miso = tx_shift[7];

  // a byte only completes inside a selected frame
  rx_in_frame: assert property (@(posedge clk) disable iff (rst)
    rx_valid |-> cs_active);

endmodule

`default_nettype wire

// ==== verilog/esp_cmd_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module esp_cmd_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rx_valid,
  input  logic [7:0]            rx_byte,
  output trs_io_pkg::cmd_exec_t cmd
);

  typedef enum logic {
    st_idle,   // next byte is an opcode
    st_param   // next byte is the parameter
  } state_t;

  state_t               state;
  logic                 valid_q;
  trs_io_pkg::cmd_op_t  op_q;
  logic [7:0]           param_q;
  logic                 known_op;
  logic                 takes_param;

  // opcode classification
  always_comb begin
    known_op    = 1'b1;
    takes_param = 1'b0;
    case (rx_byte)
      trs_io_pkg::dbus_write:       takes_param = 1'b1;
      trs_io_pkg::get_cookie,
      trs_io_pkg::get_version,
      trs_io_pkg::dbus_read,
      trs_io_pkg::abus_read,
      trs_io_pkg::data_ready,
      trs_io_pkg::get_printer_byte: known_op = 1'b1;
      default:                      known_op = 1'b0;  // silently dropped
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (rx_valid) begin
        case (state)
          st_idle: begin
            if (takes_param)
              state <= st_param;
            else
              valid_q <= known_op;  // runs at once
          end
          st_param: begin
            state   <= st_idle;
            valid_q <= 1'b1;
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // opcode and parameter latches
  always_ff @(posedge clk) begin
    if (rx_valid && state == st_idle && known_op)
      op_q <= trs_io_pkg::cmd_op_t'(rx_byte);
    if (rx_valid && state == st_param)
      param_q <= rx_byte;
  end

  assign cmd = '{valid: valid_q, op: op_q, param: param_q};

  // never two executions back to back
  cmd_single_pulse: assert property (@(posedge clk) disable iff (rst)
    valid_q |=> !valid_q);

endmodule

`default_nettype wire

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_decoder #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  trs_io_pkg::trs_bus_t bus,
  output trs_io_pkg::dev_sel_t sel
);

  logic [SYNC_STAGES-1:0] strb_sync;
  logic strb_filt, strb_filt_q;
  logic access_q;
  logic port_31, port_frehd;
  logic addr_printer, addr_fdc;

  // any strobe, must be seen in every stage to count
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_sync   <= '0;
      strb_filt_q <= 1'b0;
      access_q    <= 1'b0;
    end else begin
      strb_sync   <= {strb_sync[SYNC_STAGES-2:0], |bus.strb};
      strb_filt_q <= strb_filt;
      access_q    <= strb_filt & ~strb_filt_q;  // rising edge only
    end
  end

  assign strb_filt = &strb_sync;  // glitch filter

  // address compares
  assign port_31      = bus.addr[7:0] == trs_io_pkg::TRS_IO_PORT;
  assign port_frehd   = bus.addr[7:4] == trs_io_pkg::FREHD_PORT_HI;
  assign addr_printer = bus.addr == trs_io_pkg::PRINTER_ADDR;
  assign addr_fdc     = bus.addr == trs_io_pkg::FDC_STATUS_ADDR;

  // selects follow the raw pins
  always_comb begin
    sel.trs_io_in     = port_31 & bus.strb.in;
    sel.trs_io_out    = port_31 & bus.strb.out;
    sel.frehd_in      = port_frehd & bus.strb.in;
    sel.frehd_out     = port_frehd & bus.strb.out;
    sel.printer_wr    = addr_printer & bus.strb.wr;
    sel.printer_rd    = addr_printer & bus.strb.rd;
    sel.fdc_status_rd = addr_fdc & bus.strb.rd;
    sel.access        = access_q;
  end

endmodule

`default_nettype wire

// ==== verilog/esp_handshake.sv ====
`timescale 1ns/1ns
`default_nettype none

module esp_handshake #(
  parameter int REQ_PULSE_CYCLES = 50
) (
  input  logic                 clk,
  input  logic                 rst,
  input  trs_io_pkg::dev_sel_t sel,
  input  logic [7:0]           data,
  input  logic                 done,
  output logic                 req,
  output logic                 wait_req,
  output trs_io_pkg::esp_svc_t esp_s,
  output logic [7:0]           printer_byte,
  output logic [7:0]           printer_status
);

  localparam int CNT_W = $clog2(REQ_PULSE_CYCLES + 1);

  logic [CNT_W-1:0] req_cnt;
  logic [2:0] done_sync;
  logic done_rise;
  logic esp_sel, req_event;
  logic printer_flag;  // printer byte waiting for pickup

  assign esp_sel   = sel.trs_io_in | sel.trs_io_out | sel.frehd_in |
                     sel.frehd_out | sel.printer_wr;
  assign req_event = sel.access & esp_sel;
  assign done_rise = done_sync[1] & ~done_sync[2];

  // req pulse length
  always_ff @(posedge clk) begin
    if (rst) begin
      req     <= 1'b0;
      req_cnt <= '0;
    end else if (req_event) begin
      req     <= 1'b1;
      req_cnt <= CNT_W'(REQ_PULSE_CYCLES);
    end else if (req_cnt != '0) begin
      req_cnt <= req_cnt - 1'b1;
      if (req_cnt == CNT_W'(1))
        req <= 1'b0;
    end
  end

  // wait and printer status, released by done
  always_ff @(posedge clk) begin
    if (rst) begin
      done_sync      <= 3'b000;
      wait_req       <= 1'b0;
      printer_flag   <= 1'b0;
      printer_status <= trs_io_pkg::PRINTER_READY;
    end else begin
      done_sync <= {done_sync[1:0], done};
      if (req_event) begin
        if (sel.printer_wr) begin
          printer_flag   <= 1'b1;
          printer_status <= trs_io_pkg::PRINTER_BUSY;
        end else begin
          wait_req <= 1'b1;  // z80 stalls until serviced
        end
      end else if (done_rise) begin
        wait_req       <= 1'b0;
        printer_flag   <= 1'b0;
        printer_status <= trs_io_pkg::PRINTER_READY;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_event && sel.printer_wr)
      printer_byte <= data;
  end

  // service code encode
  always_comb begin
    if (sel.trs_io_in)       esp_s = trs_io_pkg::trs_io_in;
    else if (sel.trs_io_out) esp_s = trs_io_pkg::trs_io_out;
    else if (sel.frehd_in)   esp_s = trs_io_pkg::frehd_in;
    else if (sel.frehd_out)  esp_s = trs_io_pkg::frehd_out;
    else if (printer_flag)   esp_s = trs_io_pkg::printer_wr;
    else                     esp_s = trs_io_pkg::svc_idle;
  end

  req_bounded: assert property (@(posedge clk) disable iff (rst)
    $rose(req) |-> ##[1:REQ_PULSE_CYCLES] !req);

endmodule

`default_nettype wire

// ==== verilog/trs_data_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module trs_data_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  trs_io_pkg::cmd_exec_t cmd,
  input  trs_io_pkg::dev_sel_t  sel,
  input  trs_io_pkg::trs_bus_t  bus,
  input  logic [7:0]            printer_byte,
  input  logic [7:0]            printer_status,
  output logic [7:0]            d_out,
  output logic                  tx_load,
  output logic [7:0]            tx_byte
);

  logic       data_ready_q;  // microcontroller has data for port 31
  logic       port_31_access;
  logic       has_resp;
  logic [7:0] resp;

  assign port_31_access = sel.access & (sel.trs_io_in | sel.trs_io_out);

  always_ff @(posedge clk) begin
    if (rst)
      data_ready_q <= 1'b0;
    else if (port_31_access)
      data_ready_q <= 1'b0;
    else if (cmd.valid && cmd.op == trs_io_pkg::data_ready)
      data_ready_q <= 1'b1;
  end

  // byte the z80 reads back
  always_ff @(posedge clk) begin
    if (cmd.valid && cmd.op == trs_io_pkg::dbus_write)
      d_out <= cmd.param;
    else if (sel.access && sel.printer_rd)
      d_out <= printer_status;
    else if (sel.access && sel.fdc_status_rd)
      d_out <= data_ready_q ? 8'h00 : 8'h20;  // bit 5 set while nothing pending
  end

  // response for the next spi transfer
  always_comb begin
    has_resp = 1'b1;
    resp     = bus.data;
    case (cmd.op)
      trs_io_pkg::get_cookie:       resp = trs_io_pkg::COOKIE;
      trs_io_pkg::get_version:      resp = {trs_io_pkg::VERSION_MAJOR,
                                            trs_io_pkg::VERSION_MINOR};
      trs_io_pkg::dbus_read:        resp = bus.data;
      trs_io_pkg::get_printer_byte: resp = printer_byte;
      trs_io_pkg::abus_read:        resp = bus.addr[7:0];
      default:                      has_resp = 1'b0;  // no reply
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      tx_load <= 1'b0;
    else
      tx_load <= cmd.valid & has_resp;
  end

  always_ff @(posedge clk) begin
    if (cmd.valid && has_resp)
      tx_byte <= resp;
  end

endmodule

`default_nettype wire

// ==== verilog/trs_io_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module trs_io_top #(
  parameter int REQ_PULSE_CYCLES = 50,
  parameter int SYNC_STAGES      = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  // spi from the microcontroller
  input  logic                 sck,
  input  logic                 cs_n,
  input  logic                 mosi,
  output logic                 miso,
  // z80 expansion bus
  input  logic [15:0]          a_n,
  input  logic [7:0]           d_in,
  input  logic                 rd_n,
  input  logic                 wr_n,
  input  logic                 in_n,
  input  logic                 out_n,
  output logic [7:0]           d_out,
  output logic                 d_oe,
  // microcontroller handshake
  input  logic                 done,
  output logic                 req,
  output logic                 wait_req,
  output trs_io_pkg::esp_svc_t esp_s
);

  trs_io_pkg::trs_bus_t  bus;
  trs_io_pkg::cmd_exec_t cmd;
  trs_io_pkg::dev_sel_t  sel;
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       tx_load;
  logic [7:0] tx_byte;
  logic [7:0] printer_byte;
  logic [7:0] printer_status;

  // pins are active low, flip into the bus struct
  assign bus = '{addr: ~a_n, data: d_in,
                 strb: '{rd: ~rd_n, wr: ~wr_n, in: ~in_n, out: ~out_n}};

  assign d_oe = bus.strb.rd | bus.strb.in;  // z80 is reading from us

  spi_byte_link #(.SYNC_STAGES(SYNC_STAGES)) u_spi (
    .clk, .rst, .sck, .cs_n, .mosi,
    .rx_valid, .rx_byte, .tx_load, .tx_byte, .miso
  );

  esp_cmd_ctrl u_ctrl (.clk, .rst, .rx_valid, .rx_byte, .cmd);

  bus_decoder #(.SYNC_STAGES(SYNC_STAGES)) u_dec (.clk, .rst, .bus, .sel);

  esp_handshake #(.REQ_PULSE_CYCLES(REQ_PULSE_CYCLES)) u_hs (
    .clk, .rst, .sel, .data(bus.data), .done,
    .req, .wait_req, .esp_s, .printer_byte, .printer_status
  );

  trs_data_regs u_regs (
    .clk, .rst, .cmd, .sel, .bus, .printer_byte, .printer_status,
    .d_out, .tx_load, .tx_byte
  );

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
  input wire logic                 clk,
  input wire logic                 sck,
  input wire logic                 cs_n,
  input wire logic                 miso,
  input wire logic [7:0]           d_out,
  input wire logic                 d_oe,
  input wire logic                 req,
  input wire logic                 wait_req,
  input wire trs_io_pkg::esp_svc_t esp_s
);

  int         pass_cnt = 0;
  int         fail_cnt = 0;
  int         test_errs = 0;
  string      test_name = "";
  logic [7:0] miso_byte;      // last byte seen on miso
  int         req_run = 0;    // cycles req has been high so far
  int         req_width = 0;  // length of the last finished req pulse

  // mode 0, sample miso on sck rise
  always @(posedge sck) begin
    if (!cs_n)
      miso_byte <= {miso_byte[6:0], miso};
  end

  // req pulse length in clk cycles
  always @(posedge clk) begin
    if (req) begin
      req_run <= req_run + 1;
    end else if (req_run != 0) begin
      req_width <= req_run;
      req_run   <= 0;
    end
  end

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic compare(input string sig, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %02h expected %02h (test %s)", sig, got, exp, test_name);
      test_errs++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("test %s: %s", test_name, what);
    test_errs++;
  endtask

  task automatic check_miso(input logic [7:0] exp);
    compare("miso byte", miso_byte, exp);
  endtask

  task automatic check_d_out(input logic [7:0] exp);
    compare("d_oe", {7'h0, d_oe}, 8'h01);  // must be driving during the read
    compare("d_out", d_out, exp);
  endtask

  task automatic check_esp_s(input logic [3:0] exp);
    compare("esp_s", {4'h0, esp_s}, {4'h0, exp});
  endtask

  task automatic check_wait(input logic exp);
    compare("wait_req", {7'h0, wait_req}, {7'h0, exp});
  endtask

  task automatic check_req_width(input int exp);
    compare("req width", req_width[7:0], exp[7:0]);
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      pass_cnt++;
      $display("ok   %s", test_name);
    end else begin
      fail_cnt++;
      $display("FAIL %s (%0d errors)", test_name, test_errs);
    end
  endtask

  task automatic report_counts();
    $display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
  endtask

endmodule

`default_nettype wire

// ==== tb/tb_trs_io.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_trs_io;

  localparam int REQ_PULSE_CYCLES = 50;
  localparam int SYNC_STAGES      = 2;
  localparam int HALF_SCK         = 8;   // clk cycles per sck half period
  localparam int MAX_VECS         = 64;
  localparam int RISE_LIMIT       = 20;

  // operation codes of the vector file
  localparam logic [7:0] OP_CMD_RESP  = 8'h01;
  localparam logic [7:0] OP_CMD_PARAM = 8'h02;
  localparam logic [7:0] OP_CMD       = 8'h03;
  localparam logic [7:0] OP_MEM_READ  = 8'h04;
  localparam logic [7:0] OP_MEM_WRITE = 8'h05;
  localparam logic [7:0] OP_IO_IN     = 8'h06;
  localparam logic [7:0] OP_IO_OUT    = 8'h07;
  localparam logic [7:0] OP_DONE      = 8'h08;
  localparam logic [7:0] OP_SET_BUS   = 8'h09;
  localparam logic [7:0] OP_END       = 8'hff;

  localparam trs_io_pkg::bus_strobe_t STRB_NONE = '{rd: 1'b0, wr: 1'b0, in: 1'b0, out: 1'b0};
  localparam trs_io_pkg::bus_strobe_t STRB_RD   = '{rd: 1'b1, wr: 1'b0, in: 1'b0, out: 1'b0};
  localparam trs_io_pkg::bus_strobe_t STRB_WR   = '{rd: 1'b0, wr: 1'b1, in: 1'b0, out: 1'b0};
  localparam trs_io_pkg::bus_strobe_t STRB_IN   = '{rd: 1'b0, wr: 1'b0, in: 1'b1, out: 1'b0};
  localparam trs_io_pkg::bus_strobe_t STRB_OUT  = '{rd: 1'b0, wr: 1'b0, in: 1'b0, out: 1'b1};

  typedef struct packed {
    logic [7:0]  op;
    logic [15:0] arg;
    logic [7:0]  data;
    logic [7:0]  exp;
  } vec_t;

  logic clk, rst, sck, cs_n, mosi, done;
  logic rd_n, wr_n, in_n, out_n;
  logic [15:0] a_n;
  logic [7:0]  d_in;
  logic        miso, d_oe, req, wait_req;
  logic [7:0]  d_out;
  trs_io_pkg::esp_svc_t esp_s;

  logic [39:0] vec_mem [0:MAX_VECS-1];
  int          idx;

  trs_io_top #(.REQ_PULSE_CYCLES(REQ_PULSE_CYCLES), .SYNC_STAGES(SYNC_STAGES)) DUT (
    .clk, .rst, .sck, .cs_n, .mosi, .miso, .a_n, .d_in, .rd_n, .wr_n, .in_n, .out_n,
    .d_out, .d_oe, .done, .req, .wait_req, .esp_s
  );

  tb_checker chk (.clk, .sck, .cs_n, .miso, .d_out, .d_oe, .req, .wait_req, .esp_s);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic string op_name(input logic [7:0] op);
    case (op)
      OP_CMD_RESP:  return "command with response";
      OP_CMD_PARAM: return "command with parameter";
      OP_CMD:       return "command";
      OP_MEM_READ:  return "z80 read";
      OP_MEM_WRITE: return "z80 write";
      OP_IO_IN:     return "z80 in";
      OP_IO_OUT:    return "z80 out";
      OP_DONE:      return "done pulse";
      OP_SET_BUS:   return "bus setup";
      default:      return "unknown";
    endcase
  endfunction

  task automatic drive_strobes(input trs_io_pkg::bus_strobe_t s);
    rd_n  = ~s.rd;  // pins are active low
    wr_n  = ~s.wr;
    in_n  = ~s.in;
    out_n = ~s.out;
  endtask

  // one mode 0 byte, msb first, cs_n framed
  task automatic spi_xfer(input logic [7:0] tx);
    cs_n = 1'b0;
    for (int b = 7; b >= 0; b--) begin
      mosi = tx[b];
      repeat (HALF_SCK) @(negedge clk);
      sck = 1'b1;
      repeat (HALF_SCK) @(negedge clk);
      sck = 1'b0;
    end
    repeat (HALF_SCK) @(negedge clk);
    cs_n = 1'b1;
    repeat (HALF_SCK) @(negedge clk);  // gap, response loads here
  endtask

  // bounded wait on req (sel 0) or wait_req (sel 1)
  task automatic wait_level(input bit sel, input logic level, input int limit, input string what);
    int n;
    n = 0;
    while ((sel ? wait_req : req) !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if ((sel ? wait_req : req) !== level)
      chk.note_failure({"timed out waiting for ", what});
  endtask

  task automatic bus_read(input logic [15:0] addr, input logic [7:0] exp);
    a_n = ~addr;
    @(negedge clk);
    drive_strobes(STRB_RD);
    repeat (8) @(negedge clk);  // filter, access, then d_out load
    chk.check_d_out(exp);
    drive_strobes(STRB_NONE);
    repeat (4) @(negedge clk);
  endtask

  task automatic bus_request(input trs_io_pkg::bus_strobe_t s, input logic [15:0] addr,
                             input logic [7:0] data, input logic [3:0] svc, input logic wt);
    a_n  = ~addr;
    d_in = data;
    @(negedge clk);
    drive_strobes(s);
    wait_level(1'b0, 1'b1, RISE_LIMIT, "req to rise");
    chk.check_esp_s(svc);
    chk.check_wait(wt);
    drive_strobes(STRB_NONE);
    wait_level(1'b0, 1'b0, REQ_PULSE_CYCLES + RISE_LIMIT, "req to fall");
    @(negedge clk);  // width counter settles
    chk.check_req_width(REQ_PULSE_CYCLES);
  endtask

  task automatic done_pulse(input logic exp_wait);
    done = 1'b1;
    repeat (4) @(negedge clk);  // three flop sync plus clear
    wait_level(1'b1, 1'b0, RISE_LIMIT, "wait_req to fall");
    done = 1'b0;
    repeat (4) @(negedge clk);
    chk.check_wait(exp_wait);
  endtask

  task automatic run_vector(input int n, input vec_t v);
    chk.start_test($sformatf("%0d %s", n, op_name(v.op)));
    case (v.op)
      OP_CMD_RESP: begin
        spi_xfer(v.arg[7:0]);
        spi_xfer(8'hff);  // ignored opcode, clocks the reply out
        chk.check_miso(v.exp);
      end
      OP_CMD_PARAM: begin
        spi_xfer(v.arg[15:8]);
        spi_xfer(v.arg[7:0]);
      end
      OP_CMD:       spi_xfer(v.arg[7:0]);
      OP_MEM_READ:  bus_read(v.arg, v.exp);
      OP_MEM_WRITE: bus_request(STRB_WR, v.arg, v.data, v.exp[3:0], 1'b0);
      OP_IO_IN:     bus_request(STRB_IN, v.arg, v.data, v.exp[3:0], 1'b1);
      OP_IO_OUT:    bus_request(STRB_OUT, v.arg, v.data, v.exp[3:0], 1'b1);
      OP_DONE:      done_pulse(v.exp[0]);
      OP_SET_BUS: begin
        a_n  = ~v.arg;
        d_in = v.data;
        @(negedge clk);
      end
      default:      chk.note_failure("unknown operation code in vector file");
    endcase
    chk.end_test();
  endtask

  initial begin
    rst  = 1'b1;
    sck  = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    done = 1'b0;
    a_n  = '1;
    d_in = 8'h00;
    drive_strobes(STRB_NONE);
    for (int i = 0; i < MAX_VECS; i++)
      vec_mem[i] = {OP_END, 32'h0};  // unread lines end the run
    $readmemh("tb/trs_io_vectors.txt", vec_mem);
    repeat (3) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    idx = 0;
    while (idx < MAX_VECS && vec_mem[idx][39:32] != OP_END) begin
      run_vector(idx, vec_t'(vec_mem[idx]));
      idx++;
    end
    chk.report_counts();
    if (chk.fail_cnt == 0 && chk.pass_cnt > 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/trs_io_vectors.txt ====
// one test per word: op_arg_data_expected (hex, 8/16/8/8 bits)
// op 01 cmd+reply, 02 cmd+param, 03 cmd, 04 rd, 05 wr, 06 in, 07 out, 08 done, 09 bus setup
01_0000_00_af
01_000f_00_03
02_045a_00_00
04_1234_00_5a
09_3c81_96_00
01_0003_00_96
01_0012_00_81
05_37e8_41_04
04_37e8_00_f0
01_0010_00_41
08_0000_00_00
04_37e8_00_30
04_37e0_00_20
03_0005_00_00
04_37e0_00_00
06_001f_00_00
08_0000_00_00
04_37e0_00_20
07_00c5_77_03
08_0000_00_00
ff_0000_00_00

// ==== vlog.f ====
verilog/trs_io_pkg.sv
verilog/spi_byte_link.sv
verilog/esp_cmd_ctrl.sv
verilog/bus_decoder.sv
verilog/esp_handshake.sv
verilog/trs_data_regs.sv
verilog/trs_io_top.sv
tb/tb_checker.sv
tb/tb_trs_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run with verilator, pass is decided by the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_trs_io -o sim_trs_io \
  && ./obj_dir/sim_trs_io | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
  && echo "simulation run passed" \
  || { echo "simulation run failed"; exit 1; }
